// File: rtl/rp_bus_pkg.sv
// system bus widths, region map and address layout
// address bits 31..23 are ignored, bits 22..20 pick one of 8 regions
// each region holds a 20-bit register offset, byte addressed
package rp_bus_pkg;

  localparam int BUS_W    = 32;  // address and data width
  localparam int SEL_W    = 4;   // one select bit per byte lane
  localparam int REGION_N = 8;   // 1 MB per region

  // region numbers of the used slaves
  localparam int REGION_HK  = 0;  // housekeeping
  localparam int REGION_ADC = 1;  // ADC sample readback

  // one address word, seen raw by the master and split by the decoder and slaves
  typedef union packed {
    logic [BUS_W-1:0] raw;
    struct packed {
      logic [BUS_W-$clog2(REGION_N)-21:0] unused;  // 31..23, don't care
      logic [$clog2(REGION_N)-1:0]        region;  // 22..20
      logic [19:0]                        offset;  // 19..0
    } f;
  } sys_addr_u;

endpackage

// File: rtl/rp_analog_pkg.sv
// ADC and DAC sample widths and the shared sample type
// ADC pins deliver 16 bits, only the upper 14 carry data
// converter code is unsigned negative slope, internal words are two's complement
package rp_analog_pkg;

  localparam int ADC_RAW_W = 16;  // width of ADC pin bus
  localparam int SMP_W     = 14;  // sample width

  // internal sample, two's complement
  typedef logic signed [SMP_W-1:0] sample_t;

  // negative slope code <-> two's complement
  // keeps msb, inverts the rest, same in both directions
  function automatic logic [SMP_W-1:0] flip_code(input logic [SMP_W-1:0] w);
    return {w[SMP_W-1], ~w[SMP_W-2:0]};
  endfunction

endpackage

// File: rtl/sys_bus_if.sv
`timescale 1ns/1ps
// one decoded region of the system bus
// strobes are single cycle, addr/wdata/sel held by the master until ack
// no back-pressure, the slave must ack by itself
interface sys_bus_if;

  rp_bus_pkg::sys_addr_u              addr;   // raw word or region/offset fields
  logic [rp_bus_pkg::BUS_W-1:0]       wdata;  // write data
  logic [rp_bus_pkg::SEL_W-1:0]       sel;    // write byte select
  logic                               wen;    // write strobe
  logic                               ren;    // read strobe
  logic [rp_bus_pkg::BUS_W-1:0]       rdata;  // valid with ack
  logic                               err;    // valid with ack
  logic                               ack;    // one cycle

  // decoder side
  modport master (
    output addr, wdata, sel, wen, ren,
    input  rdata, err, ack
  );

  // register block side
  modport slave (
    input  addr, wdata, sel, wen, ren,
    output rdata, err, ack
  );

endinterface

// File: rtl/adc_frontend.sv
`timescale 1ns/1ps
// ADC capture, upper 14 of 16 pins registered once
// samples leave as two's complement, 1 cycle after the pins
// loopback path from the DAC words is combinational
module adc_frontend (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  input  logic [rp_analog_pkg::ADC_RAW_W-1:0]  adc_dat_a_i,  // ADC CH1 pins
  input  logic [rp_analog_pkg::ADC_RAW_W-1:0]  adc_dat_b_i,  // ADC CH2 pins
  input  logic                                 loop_en_i,    // digital loopback
  input  rp_analog_pkg::sample_t               dac_a_i,
  input  rp_analog_pkg::sample_t               dac_b_i,
  output rp_analog_pkg::sample_t               smp_a_o,
  output rp_analog_pkg::sample_t               smp_b_o
);

  localparam int RW = rp_analog_pkg::ADC_RAW_W;
  localparam int SW = rp_analog_pkg::SMP_W;

  logic [SW-1:0] adc_a_q;  // raw code, neg slope
  logic [SW-1:0] adc_b_q;

  // input registers, lowest 2 pin bits dropped
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end
    else
    begin
      adc_a_q <= adc_dat_a_i[RW-1 -: SW];
      adc_b_q <= adc_dat_b_i[RW-1 -: SW];
    end
  end

  // code conversion, then loopback select
  assign smp_a_o = loop_en_i ? dac_a_i : rp_analog_pkg::flip_code(adc_a_q);
  assign smp_b_o = loop_en_i ? dac_b_i : rp_analog_pkg::flip_code(adc_b_q);

endmodule

// File: rtl/hk_regs.sv
`timescale 1ns/1ps
// housekeeping registers, region 0
// 0x0 LED, 0x4 loopback flag in bit 0, 0x8/0xC DAC words a/b in bits 13..0
// writes honour byte select, holes read 0, err never set
// LED_W must not exceed the bus width
module hk_regs #(
  parameter int LED_W = 8  // LED word width
) (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  sys_bus_if.slave                bus,
  output logic [LED_W-1:0]        led_o,
  output logic                    loop_en_o,
  output rp_analog_pkg::sample_t  dac_a_o,
  output rp_analog_pkg::sample_t  dac_b_o
);

  localparam int BW = rp_bus_pkg::BUS_W;
  localparam int SW = rp_analog_pkg::SMP_W;

  // register offsets
  localparam logic [19:0] OFFS_LED  = 20'h0;
  localparam logic [19:0] OFFS_LOOP = 20'h4;
  localparam logic [19:0] OFFS_DACA = 20'h8;
  localparam logic [19:0] OFFS_DACB = 20'hC;

  logic [LED_W-1:0]       led_q;
  logic                   loop_q;
  rp_analog_pkg::sample_t dac_a_q, dac_b_q;
  logic [BW-1:0]          rd_word;  // addressed register, zero-extended
  logic [BW-1:0]          wr_word;  // rd_word with selected lanes replaced
  logic [BW-1:0]          rdata_q;
  logic                   ack_q;

  // replace the byte lanes picked by sel
  function automatic logic [BW-1:0] merge_bytes(
    input logic [BW-1:0]                  cur,
    input logic [BW-1:0]                  wd,
    input logic [rp_bus_pkg::SEL_W-1:0]   sel
  );
    logic [BW-1:0] res;
    res = cur;
    for (int i = 0; i < rp_bus_pkg::SEL_W; i++)
    begin
      if (sel[i])
        res[8*i +: 8] = wd[8*i +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // read mux and write merge
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (bus.addr.f.offset)
      OFFS_LED:  rd_word = BW'(led_q);
      OFFS_LOOP: rd_word = BW'(loop_q);
      OFFS_DACA: rd_word = {{(BW-SW){1'b0}}, dac_a_q};  // no sign extension here
      OFFS_DACB: rd_word = {{(BW-SW){1'b0}}, dac_b_q};
      default:   rd_word = '0;
    endcase
  end

  assign wr_word = merge_bytes(rd_word, bus.wdata, bus.sel);

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      led_q   <= '0;
      loop_q  <= 1'b0;
      dac_a_q <= '0;
      dac_b_q <= '0;
    end
    else if (bus.wen)
    begin
      case (bus.addr.f.offset)
        OFFS_LED:  led_q   <= wr_word[LED_W-1:0];
        OFFS_LOOP: loop_q  <= wr_word[0];
        OFFS_DACA: dac_a_q <= wr_word[SW-1:0];
        OFFS_DACB: dac_b_q <= wr_word[SW-1:0];
        default:   ;  // hole, dropped
      endcase
    end
  end

  // ack one cycle after any strobe
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus.wen | bus.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus.ren)
      rdata_q <= rd_word;  // sampled at strobe
  end

  assign bus.rdata = rdata_q;
  assign bus.err   = 1'b0;
  assign bus.ack   = ack_q;

  assign led_o     = led_q;
  assign loop_en_o = loop_q;
  assign dac_a_o   = dac_a_q;
  assign dac_b_o   = dac_b_q;

endmodule

// File: rtl/adc_sample_regs.sv
`timescale 1ns/1ps
// read-only sample readback, region 1
// 0x0 sample a, 0x4 sample b, sign-extended to 32 bits, other offsets read 0
// writes ack with err set and change nothing
module adc_sample_regs (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  rp_analog_pkg::sample_t  smp_a_i,
  input  rp_analog_pkg::sample_t  smp_b_i,
  sys_bus_if.slave                bus
);

  localparam int BW = rp_bus_pkg::BUS_W;

  localparam logic [19:0] OFFS_SMPA = 20'h0;
  localparam logic [19:0] OFFS_SMPB = 20'h4;

  logic [BW-1:0] rd_word;
  logic [BW-1:0] rdata_q;
  logic          ack_q;
  logic          err_q;

  // sample_t is signed, so the cast sign-extends
  always_comb
  begin
    case (bus.addr.f.offset)
      OFFS_SMPA: rd_word = BW'(smp_a_i);
      OFFS_SMPB: rd_word = BW'(smp_b_i);
      default:   rd_word = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= bus.wen | bus.ren;
      err_q <= bus.wen;  // read-only region
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus.ren)
      rdata_q <= rd_word;
  end

  assign bus.rdata = rdata_q;
  assign bus.err   = err_q;
  assign bus.ack   = ack_q;

endmodule

// File: rtl/sys_bus_decoder.sv
`timescale 1ns/1ps
// splits the system bus into 8 regions by address bits 22..20
// region 0 and 1 go to register slaves, 2..7 ack in the strobe cycle with 0 data
// response follows the current address, which the master holds until ack
module sys_bus_decoder (
  input  logic                          adc_clk,
  input  logic [rp_bus_pkg::BUS_W-1:0]  sys_addr_i,
  input  logic [rp_bus_pkg::BUS_W-1:0]  sys_wdata_i,
  input  logic [rp_bus_pkg::SEL_W-1:0]  sys_sel_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [rp_bus_pkg::BUS_W-1:0]  sys_rdata_o,
  output logic                          sys_err_o,
  output logic                          sys_ack_o,
  sys_bus_if.master                     hk_bus,   // region 0
  sys_bus_if.master                     smp_bus   // region 1
);

  localparam int BW = rp_bus_pkg::BUS_W;
  localparam int RN = rp_bus_pkg::REGION_N;
  localparam int HK = rp_bus_pkg::REGION_HK;
  localparam int AD = rp_bus_pkg::REGION_ADC;

  rp_bus_pkg::sys_addr_u        addr_u;
  logic [$clog2(RN)-1:0]        region;
  logic [RN-1:0]                cs;        // one-hot region select
  logic                         stb;       // any strobe
  logic [RN-1:0]                stb_cs_q;  // region strobed last cycle
  logic [BW-1:0]                rdata_r [RN];
  logic [RN-1:0]                err_r;
  logic [RN-1:0]                ack_r;

  assign addr_u.raw = sys_addr_i;
  assign region     = addr_u.f.region;
  assign cs         = RN'(1) << region;
  assign stb        = sys_wen_i | sys_ren_i;

  ////////////////////////////////////////////////////////////
  // request side, strobes only to the selected region
  ////////////////////////////////////////////////////////////

  assign hk_bus.addr   = addr_u;
  assign hk_bus.wdata  = sys_wdata_i;
  assign hk_bus.sel    = sys_sel_i;
  assign hk_bus.wen    = sys_wen_i & cs[HK];
  assign hk_bus.ren    = sys_ren_i & cs[HK];

  assign smp_bus.addr  = addr_u;
  assign smp_bus.wdata = sys_wdata_i;
  assign smp_bus.sel   = sys_sel_i;
  assign smp_bus.wen   = sys_wen_i & cs[AD];
  assign smp_bus.ren   = sys_ren_i & cs[AD];

  // slaves ack one cycle after their strobe, so only accept an ack
  // from the region that was actually strobed
  always_ff @(posedge adc_clk)
    stb_cs_q <= cs & {RN{stb}};

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int r = 0; r < RN; r++)
    begin
      rdata_r[r] = '0;   // unused regions
      err_r[r]   = 1'b0;
      ack_r[r]   = stb;  // answer at once
    end
    rdata_r[HK] = hk_bus.rdata;
    err_r[HK]   = hk_bus.err;
    ack_r[HK]   = hk_bus.ack & stb_cs_q[HK];
    rdata_r[AD] = smp_bus.rdata;
    err_r[AD]   = smp_bus.err;
    ack_r[AD]   = smp_bus.ack & stb_cs_q[AD];
  end

  assign sys_rdata_o = rdata_r[region];
  assign sys_err_o   = err_r[region];
  assign sys_ack_o   = ack_r[region];

endmodule

// File: rtl/dac_output.sv
`timescale 1ns/1ps
// DAC output, both channels interleaved on one 14-bit bus at adc_clk rate
// sel high -> channel b on the bus, sel low -> channel a
// a new DAC word shows on the bus within 2 cycles
module dac_output (
  input  logic                              adc_clk,
  input  logic                              rst_n_i,
  input  rp_analog_pkg::sample_t            dac_a_i,
  input  rp_analog_pkg::sample_t            dac_b_i,
  output logic [rp_analog_pkg::SMP_W-1:0]   dac_dat_o,  // neg slope code
  output logic                              dac_sel_o,  // channel select
  output logic                              dac_rst_o   // active high
);

  localparam int SW = rp_analog_pkg::SMP_W;

  logic [SW-1:0] code_a, code_b;  // converted words
  logic [SW-1:0] dat_q;
  logic          sel_q;
  logic          rst_q;

  // two's complement -> neg slope
  assign code_a = rp_analog_pkg::flip_code(dac_a_i);
  assign code_b = rp_analog_pkg::flip_code(dac_b_i);

  // register the word of the channel that comes next
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sel_q <= 1'b0;
      dat_q <= rp_analog_pkg::flip_code('0);  // code of zero
    end
    else
    begin
      sel_q <= ~sel_q;
      dat_q <= sel_q ? code_a : code_b;  // next phase is ~sel_q
    end
  end

  // DAC reset, high in reset and one cycle after
  always_ff @(posedge adc_clk)
    rst_q <= ~rst_n_i;

  assign dac_dat_o = dat_q;
  assign dac_sel_o = sel_q;
  assign dac_rst_o = rst_q;

endmodule

// File: rtl/rp_analog_top.sv
`timescale 1ns/1ps
// analog front end with system bus skeleton, single clock adc_clk
// region 0 housekeeping, region 1 ADC readback, regions 2..7 unused
// DAC runs single rate, channels interleaved by dac_sel_o
module rp_analog_top #(
  parameter int LED_W = 8  // LED word width
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,      // sync, active low
  // ADC
  input  logic [rp_analog_pkg::ADC_RAW_W-1:0]  adc_dat_a_i,  // CH1
  input  logic [rp_analog_pkg::ADC_RAW_W-1:0]  adc_dat_b_i,  // CH2
  // system bus
  input  logic [rp_bus_pkg::BUS_W-1:0]         sys_addr_i,
  input  logic [rp_bus_pkg::BUS_W-1:0]         sys_wdata_i,
  input  logic [rp_bus_pkg::SEL_W-1:0]         sys_sel_i,
  input  logic                                 sys_wen_i,
  input  logic                                 sys_ren_i,
  output logic [rp_bus_pkg::BUS_W-1:0]         sys_rdata_o,
  output logic                                 sys_err_o,
  output logic                                 sys_ack_o,
  // DAC
  output logic [rp_analog_pkg::SMP_W-1:0]      dac_dat_o,
  output logic                                 dac_sel_o,
  output logic                                 dac_rst_o,
  // LED
  output logic [LED_W-1:0]                     led_o
);

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  sys_bus_if hk_bus ();   // region 0
  sys_bus_if smp_bus ();  // region 1

  logic                   loop_en;       // digital loopback
  rp_analog_pkg::sample_t dac_a, dac_b;  // DAC words from housekeeping
  rp_analog_pkg::sample_t smp_a, smp_b;  // ADC samples or looped DAC words

  ////////////////////////////////////////////////////////////
  // bus decode
  ////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_sel_i   (sys_sel_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .hk_bus      (hk_bus.master),
    .smp_bus     (smp_bus.master)
  );

  ////////////////////////////////////////////////////////////
  // register slaves
  ////////////////////////////////////////////////////////////

  hk_regs #(
    .LED_W (LED_W)
  ) i_hk (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .bus       (hk_bus.slave),
    .led_o     (led_o),
    .loop_en_o (loop_en),
    .dac_a_o   (dac_a),
    .dac_b_o   (dac_b)
  );

  adc_sample_regs i_smp (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .smp_a_i (smp_a),
    .smp_b_i (smp_b),
    .bus     (smp_bus.slave)
  );

  ////////////////////////////////////////////////////////////
  // analog IO
  ////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .smp_a_o     (smp_a),
    .smp_b_o     (smp_b)
  );

  dac_output i_dac (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .dac_a_i   (dac_a),
    .dac_b_i   (dac_b),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps
// testbench clock and synchronous reset
// reset released 1 ns after the RST_CYC-th rising edge
module tb_clkgen #(
  parameter int PERIOD_NS = 4,  // even number of ns
  parameter int RST_CYC   = 8   // cycles in reset
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYC) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;  // moves like any other stimulus
  end

endmodule

// File: tb/tb_checker.sv
`timescale 1ns/1ps
// watches the DUT pins and keeps its own image of the registers
// samples on the falling edge, stimulus moves 1 ns after the rising edge
// ADC pins assumed steady for 2 cycles before a region 1 read
module tb_checker #(
  parameter int LED_W = 8
) (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic [15:0]       adc_a_i,
  input  logic [15:0]       adc_b_i,
  input  logic [31:0]       addr_i,
  input  logic [31:0]       wdata_i,
  input  logic [3:0]        sel_i,
  input  logic              wen_i,
  input  logic              ren_i,
  input  logic [31:0]       rdata_i,
  input  logic              err_i,
  input  logic              ack_i,
  input  logic [13:0]       dac_dat_i,
  input  logic              dac_sel_i,
  input  logic              dac_rst_i,
  input  logic [LED_W-1:0]  led_i,
  output int                err_cnt_o,
  output int                chk_cnt_o
);

  localparam logic [31:0] LED_MASK = 32'hFFFF_FFFF >> (32 - LED_W);

  logic [31:0] led_m, loop_m, dac_a_m, dac_b_m;  // expected register contents
  logic [31:0] req_addr, req_wdata;              // request waiting for its ack
  logic [3:0]  req_sel;
  logic        req_wr, req_pend;
  logic        sel_prev;
  int          settle;     // cycles since last housekeeping write
  int          since_rst;  // cycles since reset release
  int          err_cnt, chk_cnt;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  initial
  begin
    err_cnt  = 0;
    chk_cnt  = 0;
    req_pend = 1'b0;
  end

  // neg slope code and two's complement map onto each other as 8191 - x,
  // mod 2^14, so signed or unsigned x gives the same word
  function automatic logic [13:0] slope_code(input int x);
    int r;
    r = 8191 - x;
    return r[13:0];
  endfunction

  function automatic logic [31:0] sext14(input logic [13:0] w);
    return {{18{w[13]}}, w};
  endfunction

  // byte lanes picked by sel come from wd
  function automatic logic [31:0] lanes(input logic [31:0] cur, input logic [31:0] wd,
                                        input logic [3:0] sel);
    logic [31:0] m;
    m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (cur & ~m) | (wd & m);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model of a read
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] expect_rdata(input logic [31:0] a);
    logic [19:0] off;
    logic [31:0] r;
    off = a[19:0];
    r   = '0;
    case (a[22:20])
      3'd0:  // housekeeping, holes read 0
        case (off)
          20'h0:   r = led_m;
          20'h4:   r = loop_m;
          20'h8:   r = dac_a_m;
          20'hC:   r = dac_b_m;
          default: r = '0;
        endcase
      3'd1:
        if (off == 20'h0)
          r = sext14(loop_m[0] ? dac_a_m[13:0] : slope_code(int'(adc_a_i[15:2])));
        else if (off == 20'h4)
          r = sext14(loop_m[0] ? dac_b_m[13:0] : slope_code(int'(adc_b_i[15:2])));
      default: r = '0;  // unused regions
    endcase
    return r;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[FAIL] %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // response of the pending request, then the write lands in the image
  task automatic check_response();
    logic [2:0] region;
    region = req_addr[22:20];
    compare("sys_err_o", 32'(err_i), 32'(req_wr && region == 3'd1));
    if (!req_wr || region > 3'd1)
      compare($sformatf("rdata at 0x%08h", req_addr), rdata_i, expect_rdata(req_addr));
    if (req_wr && region == 3'd0)
    begin
      settle = 0;
      case (req_addr[19:0])
        20'h0:   led_m   = lanes(led_m, req_wdata, req_sel) & LED_MASK;
        20'h4:   loop_m  = lanes(loop_m, req_wdata, req_sel) & 32'h1;
        20'h8:   dac_a_m = lanes(dac_a_m, req_wdata, req_sel) & 32'h3FFF;
        20'hC:   dac_b_m = lanes(dac_b_m, req_wdata, req_sel) & 32'h3FFF;
        default: ;
      endcase
    end
    req_pend = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////

  always @(negedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      led_m     = '0;
      loop_m    = '0;
      dac_a_m   = '0;
      dac_b_m   = '0;
      req_pend  = 1'b0;
      settle    = 0;
      since_rst = 0;
    end
    else
    begin
      if (since_rst < 3)
        since_rst++;
      if (settle < 3)
        settle++;
      if (wen_i || ren_i)
      begin
        if (req_pend)
        begin
          err_cnt++;
          $display("new request at %0d ns while the last one has no ack", $time);
        end
        req_addr  = addr_i;
        req_wdata = wdata_i;
        req_sel   = sel_i;
        req_wr    = wen_i;
        req_pend  = 1'b1;
      end
      if (ack_i && req_pend)
        check_response();
      else if (ack_i)
      begin
        err_cnt++;
        $display("ack at %0d ns without a pending request", $time);
      end
      compare("led_o", 32'(led_i), led_m);
      compare("dac_rst_o", 32'(dac_rst_i), 32'(since_rst < 2));  // high 1 cycle past reset
      if (since_rst >= 2 && dac_sel_i == sel_prev)
      begin
        err_cnt++;
        $display("dac_sel_o did not toggle at %0d ns", $time);
      end
      if (settle >= 2)  // new DAC word needs 2 cycles
        compare($sformatf("dac_dat_o, sel %0d", dac_sel_i), 32'(dac_dat_i),
                32'(slope_code(int'(dac_sel_i ? dac_b_m[13:0] : dac_a_m[13:0]))));
      sel_prev = dac_sel_i;
    end
  end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps
// testbench top, one bus transfer at a time, strobes last one cycle
// stimulus moves 1 ns after the rising edge, acks sampled on the falling edge
// random words from a 16-bit Fibonacci LFSR, seed 4
module tb_top;

  localparam int LED_W   = 8;
  localparam int CLK_NS  = 4;
  localparam int RST_CYC = 8;
  localparam int NUM_TXN = 111;  // bus transfers in the sequence below
  localparam int TXN_CYC = 8;    // bound per transfer, idle cycles included
  localparam int ACK_MAX = 8;    // cycles to wait for one ack

  localparam logic [31:0] HK_LED   = 32'h0000_0000;
  localparam logic [31:0] HK_LOOP  = 32'h0000_0004;
  localparam logic [31:0] HK_DACA  = 32'h0000_0008;
  localparam logic [31:0] HK_DACB  = 32'h0000_000C;
  localparam logic [31:0] ADC_SMPA = 32'h0010_0000;
  localparam logic [31:0] ADC_SMPB = 32'h0010_0004;

  logic             adc_clk, rst_n;
  logic [15:0]      adc_dat_a, adc_dat_b;
  logic [31:0]      sys_addr, sys_wdata, sys_rdata;
  logic [3:0]       sys_sel;
  logic             sys_wen, sys_ren, sys_err, sys_ack;
  logic [13:0]      dac_dat;
  logic             dac_sel, dac_rst;
  logic [LED_W-1:0] led;
  logic [15:0]      lfsr;        // LFSR state
  int               err_cnt, chk_cnt;
  int               proto_errs;  // missing acks, stuck DAC reset

  tb_clkgen #(.PERIOD_NS (CLK_NS), .RST_CYC (RST_CYC)) i_clk (
    .clk_o   (adc_clk),
    .rst_n_o (rst_n)
  );

  rp_analog_top #(.LED_W (LED_W)) UUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_sel_i   (sys_sel),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_err_o   (sys_err),
    .sys_ack_o   (sys_ack),
    .dac_dat_o   (dac_dat),
    .dac_sel_o   (dac_sel),
    .dac_rst_o   (dac_rst),
    .led_o       (led)
  );

  tb_checker #(.LED_W (LED_W)) i_chk (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n),
    .adc_a_i   (adc_dat_a),
    .adc_b_i   (adc_dat_b),
    .addr_i    (sys_addr),
    .wdata_i   (sys_wdata),
    .sel_i     (sys_sel),
    .wen_i     (sys_wen),
    .ren_i     (sys_ren),
    .rdata_i   (sys_rdata),
    .err_i     (sys_err),
    .ack_i     (sys_ack),
    .dac_dat_i (dac_dat),
    .dac_sel_i (dac_sel),
    .dac_rst_i (dac_rst),
    .led_i     (led),
    .err_cnt_o (err_cnt),
    .chk_cnt_o (chk_cnt)
  );

  // one step per bit taken, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  ////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////

  task automatic bus_xfer(input logic wr, input logic [31:0] a, input logic [31:0] wd,
                          input logic [3:0] sel);
    logic acked;
    int   waited;
    @(posedge adc_clk);
    #1;
    sys_addr  = a;
    sys_wdata = wd;
    sys_sel   = sel;
    sys_wen   = wr;
    sys_ren   = ~wr;
    @(negedge adc_clk);
    acked = sys_ack;  // unused regions answer at once
    @(posedge adc_clk);
    #1;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    waited  = 0;
    while (!acked && waited < ACK_MAX)
    begin
      @(negedge adc_clk);
      acked = sys_ack;
      waited++;
    end
    if (!acked)
    begin
      proto_errs++;
      $display("no ack within %0d cycles for %s at 0x%08h", ACK_MAX, wr ? "write" : "read", a);
    end
  endtask

  task automatic wr_reg(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] sel);
    bus_xfer(1'b1, a, wd, sel);
  endtask

  task automatic rd_reg(input logic [31:0] a);
    bus_xfer(1'b0, a, 32'h0, 4'h0);
  endtask

  // new ADC pins, held until the input register has them
  task automatic set_adc(input logic [15:0] a, input logic [15:0] b);
    @(posedge adc_clk);
    #1;
    adc_dat_a = a;
    adc_dat_b = b;
    idle(2);
  endtask

  task automatic wait_dac_reset();
    int n;
    n = 0;
    while (dac_rst && n < 4)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (dac_rst)
    begin
      proto_errs++;
      $display("dac_rst_o still high %0d cycles after reset release", n);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    lfsr       = 16'd4;
    proto_errs = 0;
    adc_dat_a  = '0;
    adc_dat_b  = '0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_sel    = '0;
    sys_wen    = 1'b0;
    sys_ren    = 1'b0;
    @(posedge rst_n);
    wait_dac_reset();
    rd_reg(HK_LED);  // reset values
    rd_reg(HK_LOOP);
    rd_reg(HK_DACA);
    rd_reg(HK_DACB);
    for (int i = 0; i < 8; i++)
    begin
      wr_reg(HK_LED, rand_bits(32), 4'hF);
      rd_reg(HK_LED);
      wr_reg(HK_DACA, rand_bits(32), 4'hF);
      rd_reg(HK_DACA);
      wr_reg(HK_DACB, rand_bits(32), 4'hF);
      rd_reg(HK_DACB);
      idle(2);  // DAC bus settles
    end
    wr_reg(HK_DACA, rand_bits(32), 4'b0001);  // low byte only
    rd_reg(HK_DACA);
    wr_reg(HK_LED, rand_bits(32), 4'b0010);   // lane above the LED word
    rd_reg(HK_LED);
    // ADC readback, loopback off
    wr_reg(HK_LOOP, 32'h0, 4'hF);
    for (int i = 0; i < 8; i++)
    begin
      set_adc(16'(rand_bits(16)), 16'(rand_bits(16)));
      rd_reg(ADC_SMPA);
      rd_reg(ADC_SMPB);
    end
    rd_reg(ADC_SMPA + 32'h8);              // hole
    wr_reg(ADC_SMPA, rand_bits(32), 4'hF);  // read only, err expected
    // loopback
    wr_reg(HK_LOOP, 32'h1, 4'hF);
    rd_reg(HK_LOOP);
    for (int i = 0; i < 4; i++)
    begin
      wr_reg(HK_DACA, rand_bits(32), 4'hF);
      wr_reg(HK_DACB, rand_bits(32), 4'hF);
      rd_reg(ADC_SMPA);
      rd_reg(ADC_SMPB);
      idle(3);
    end
    // unused regions must not touch housekeeping
    for (int r = 2; r < 8; r++)
    begin
      wr_reg((32'(r) << 20) | 32'h8, rand_bits(32), 4'hF);
      rd_reg((32'(r) << 20) | 32'h8);
    end
    rd_reg(HK_LED);
    rd_reg(HK_LOOP);
    rd_reg(HK_DACA);
    rd_reg(HK_DACB);
    rd_reg(32'h0000_0010);
    rd_reg(32'h0000_0040);
    idle(4);
    $display("errors: %0d value, %0d protocol, %0d checks done", err_cnt, proto_errs, chk_cnt);
    if (err_cnt == 0 && proto_errs == 0 && chk_cnt > 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #((RST_CYC + NUM_TXN * TXN_CYC) * CLK_NS);
    $display("watchdog expired at %0d ns, sequence did not finish", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: list.f
rtl/rp_bus_pkg.sv
rtl/rp_analog_pkg.sv
rtl/sys_bus_if.sv
rtl/adc_frontend.sv
rtl/hk_regs.sv
rtl/adc_sample_regs.sv
rtl/sys_bus_decoder.sv
rtl/dac_output.sv
rtl/rp_analog_top.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root
# exit status 0 only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f list.f \
  && ./obj_dir/Vtb_top | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && echo "simulation ok" \
  || { echo "simulation did not pass"; exit 1; }
